//--- Makefile
SIM      = verilator
SIMFLAGS = --binary --timing --assert -Wno-fatal
TOP      = execClusterTb
FILELIST = all.f
BUILDDIR = obj_dir
BIN      = $(BUILDDIR)/V$(TOP)
LOG      = sim.log
SOURCES  = $(shell grep -v '^+' $(FILELIST)) tests/execModel.svh

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(SIMFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILDDIR)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "Simulation completed successfully" $(LOG)

clean:
	rm -rf $(BUILDDIR) $(LOG)

//--- all.f
+incdir+tests
common/isaDefs.sv
common/clusterDefs.sv
execute/aluCore.sv
execute/execLane.sv
src/execDispatch.sv
src/execCollect.sv
src/execCluster.sv
tests/execClusterTb.sv

//--- common/clusterDefs.sv
////////////////////
// Sizing of the execute cluster
// Lane count, per-lane queue depth and downstream credits
////////////////////
package clusterDefs;

    localparam int NUM_LANES   = 4;
    localparam int LANE_DEPTH  = 2;
    localparam int LANE_PTR_W  = $clog2(LANE_DEPTH);
    localparam int OUT_CREDITS = 4;

    typedef logic [$clog2(NUM_LANES)-1:0] laneIdx;

    // Holds 0 up to the larger of LANE_DEPTH and OUT_CREDITS
    typedef logic [2:0] creditCnt;

endpackage

//--- common/isaDefs.sv
////////////////////
// Operation codes and datapath types for the execute stage
// Imported by the ALU, the lanes, the cluster top and the reference model
////////////////////
package isaDefs;

    localparam int WORD_W  = 16;
    localparam int SHAMT_W = 4;

    typedef logic [WORD_W-1:0] word;
    typedef logic [4:0]        execOp;
    typedef logic [2:0]        aluOper;

    // Execute operation codes
    localparam execOp OP_ADD  = 5'h00;
    localparam execOp OP_SUB  = 5'h01;
    localparam execOp OP_XOR  = 5'h02;
    localparam execOp OP_ANDN = 5'h03;
    localparam execOp OP_ROL  = 5'h04;
    localparam execOp OP_SLL  = 5'h05;
    localparam execOp OP_ROR  = 5'h06;
    localparam execOp OP_SRL  = 5'h07;
    localparam execOp OP_SLBI = 5'h08;
    localparam execOp OP_SEQ  = 5'h09;
    localparam execOp OP_SLT  = 5'h0a;
    localparam execOp OP_SLE  = 5'h0b;
    localparam execOp OP_SCO  = 5'h0c;
    localparam execOp OP_BTR  = 5'h0d;
    localparam execOp OP_JR   = 5'h0e;

    // ALU function select
    localparam aluOper ALU_ADD  = 3'd0;
    localparam aluOper ALU_XOR  = 3'd1;
    localparam aluOper ALU_ANDN = 3'd2;
    localparam aluOper ALU_ROL  = 3'd3;
    localparam aluOper ALU_SLL  = 3'd4;
    localparam aluOper ALU_ROR  = 3'd5;
    localparam aluOper ALU_SRL  = 3'd6;

endpackage

//--- execute/aluCore.sv
////////////////////
// Combinational 16-bit ALU of one execute lane
// Operands are optionally inverted, then added, XORed, AND-NOTed,
// rotated or shifted; shift amount is the low nibble of inB
////////////////////
module aluCore (
    input  isaDefs::word    inA,
    input  isaDefs::word    inB,
    input  logic            cin,
    input  isaDefs::aluOper oper,
    input  logic            invA,
    input  logic            invB,
    input  logic            isSigned,
    output isaDefs::word    result,
    output logic            zero,
    output logic            ltz,
    output logic            ofl
);
    import isaDefs::*;

    word                 opA;
    word                 opB;
    logic [WORD_W:0]     sum;
    logic [SHAMT_W-1:0]  shamt;
    logic [2*WORD_W-1:0] rolWide;
    logic [2*WORD_W-1:0] rorWide;
    logic                addOfl;

    assign opA   = invA ? ~inA : inA;
    assign opB   = invB ? ~inB : inB;
    assign shamt = opB[SHAMT_W-1:0];

    assign sum = {1'b0, opA} + {1'b0, opB} + {{WORD_W{1'b0}}, cin};

    // Rotates via a doubled copy of the operand
    assign rolWide = {opA, opA} << shamt;
    assign rorWide = {opA, opA} >> shamt;

    // Addends agree in sign but the sum does not
    assign addOfl = (opA[WORD_W-1] == opB[WORD_W-1]) &&
                    (sum[WORD_W-1] != opA[WORD_W-1]);

    always_comb begin
        case (oper)
            ALU_ADD: begin
                result = sum[WORD_W-1:0];
            end
            ALU_XOR: begin
                result = opA ^ opB;
            end
            ALU_ANDN: begin
                result = opA & ~opB;
            end
            ALU_ROL: begin
                result = rolWide[2*WORD_W-1:WORD_W];
            end
            ALU_SLL: begin
                result = opA << shamt;
            end
            ALU_ROR: begin
                result = rorWide[WORD_W-1:0];
            end
            ALU_SRL: begin
                result = opA >> shamt;
            end
            default: begin
                result = sum[WORD_W-1:0];
            end
        endcase
    end

    assign zero = (result == '0);
    assign ofl  = isSigned && (oper == ALU_ADD) && addOfl;

    // True sign of the sum when signed, no carry out when unsigned
    assign ltz = isSigned ? (sum[WORD_W-1] ^ addOfl) : ~sum[WORD_W];

endmodule

//--- execute/execLane.sv
////////////////////
// One execute lane: small operation queue, execute datapath and
// a result register that holds until the collector takes it
// Returns a credit pulse to the dispatcher on every queue pop
////////////////////
module execLane (
    input  logic           clk,
    input  logic           rstN,
    input  logic           write,
    input  isaDefs::execOp op,
    input  isaDefs::word   opA,
    input  isaDefs::word   opB,
    input  isaDefs::word   imm,
    input  isaDefs::word   pc,
    output logic           credit,
    output logic           resValid,
    input  logic           take,
    output isaDefs::word   res,
    output isaDefs::word   brAddr,
    output isaDefs::word   jumpAddr,
    output logic           err
);
    import isaDefs::*;
    import clusterDefs::*;

    execOp opMem  [LANE_DEPTH];
    word   aMem   [LANE_DEPTH];
    word   bMem   [LANE_DEPTH];
    word   immMem [LANE_DEPTH];
    word   pcMem  [LANE_DEPTH];

    logic [LANE_PTR_W-1:0] wrPtr;
    logic [LANE_PTR_W-1:0] rdPtr;
    logic [LANE_PTR_W:0]   count;
    logic                  pop;

    execOp  qOp;
    word    qA;
    word    qB;
    word    qImm;
    word    qPc;
    aluOper aluSel;
    word    aluInB;
    logic   aluInvA;
    logic   aluCin;
    logic   aluSigned;
    word    aluRes;
    logic   aluZero;
    logic   aluLtz;
    logic   aluOfl;
    logic   setHit;
    logic   isSet;
    word    btrRes;
    word    nextRes;
    word    jumpBase;
    logic [WORD_W:0] brSum;

    assign pop    = (count != '0) && (!resValid || take);
    assign credit = pop;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (write) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (pop) begin
                rdPtr <= rdPtr + 1'b1;
            end
            count <= count + write - pop;
        end
    end

    always_ff @(posedge clk) begin
        if (write) begin
            opMem[wrPtr]  <= op;
            aMem[wrPtr]   <= opA;
            bMem[wrPtr]   <= opB;
            immMem[wrPtr] <= imm;
            pcMem[wrPtr]  <= pc;
        end
    end

    assign qOp  = opMem[rdPtr];
    assign qA   = aMem[rdPtr];
    assign qB   = bMem[rdPtr];
    assign qImm = immMem[rdPtr];
    assign qPc  = pcMem[rdPtr];

    // Decode to ALU controls; subtract and compare compute B - A
    always_comb begin
        aluSel    = ALU_ADD;
        aluInB    = qB;
        aluInvA   = 1'b0;
        aluCin    = 1'b0;
        aluSigned = 1'b1;
        case (qOp)
            OP_SUB, OP_SEQ, OP_SLT, OP_SLE: begin
                aluInvA = 1'b1;
                aluCin  = 1'b1;
            end
            OP_XOR:  aluSel = ALU_XOR;
            OP_ANDN: aluSel = ALU_ANDN;
            OP_ROL:  aluSel = ALU_ROL;
            OP_SLL:  aluSel = ALU_SLL;
            OP_SRL:  aluSel = ALU_SRL;
            OP_ROR: begin
                // Rotate left by the negated amount
                aluSel = ALU_ROL;
                aluInB = '0 - qB;
            end
            OP_SCO:  aluSigned = 1'b0;
            default: ;
        endcase
    end

    aluCore i_alu (
        .inA      (qA),
        .inB      (aluInB),
        .cin      (aluCin),
        .oper     (aluSel),
        .invA     (aluInvA),
        .invB     (1'b0),
        .isSigned (aluSigned),
        .result   (aluRes),
        .zero     (aluZero),
        .ltz      (aluLtz),
        .ofl      (aluOfl)
    );

    always_comb begin
        case (qOp)
            OP_SEQ:  setHit = aluZero;
            OP_SLT:  setHit = !aluLtz && !aluZero;
            OP_SLE:  setHit = !aluLtz;
            OP_SCO:  setHit = !aluLtz;
            default: setHit = 1'b0;
        endcase
    end

    assign isSet  = (qOp == OP_SEQ) || (qOp == OP_SLT) || (qOp == OP_SLE) || (qOp == OP_SCO);
    assign btrRes = {<<{qB}};

    always_comb begin
        if (isSet) begin
            nextRes = {{(WORD_W-1){1'b0}}, setHit};
        end else if (qOp == OP_SLBI) begin
            nextRes = {qB[7:0], 8'h00} | qImm;
        end else if (qOp == OP_BTR) begin
            nextRes = btrRes;
        end else begin
            nextRes = aluRes;
        end
    end

    assign brSum    = {1'b0, qPc} + {1'b0, qImm};
    assign jumpBase = (qOp == OP_JR) ? qA : qPc;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            resValid <= 1'b0;
        end else if (pop) begin
            resValid <= 1'b1;
        end else if (take) begin
            resValid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            res      <= nextRes;
            brAddr   <= brSum[WORD_W-1:0];
            jumpAddr <= jumpBase + qImm;
            err      <= (aluOfl && (qOp == OP_ADD || qOp == OP_SUB)) || brSum[WORD_W];
        end
    end

    // Dispatcher credits must keep the queue from overflowing
    noWriteWhenFull: assert property (@(posedge clk) disable iff (!rstN)
        write |-> (count < LANE_DEPTH));

    // Collector only takes a presented result
    takeOnlyValid: assert property (@(posedge clk) disable iff (!rstN)
        take |-> resValid);

endmodule

//--- src/execCluster.sv
////////////////////
// Integer execute cluster top: dispatcher, four lanes, collector
// Upstream valid/ready in, in-order credited results out
////////////////////
module execCluster (
    input  logic           clk,
    input  logic           rstN,
    input  logic           inValid,
    input  isaDefs::execOp inOp,
    input  isaDefs::word   inA,
    input  isaDefs::word   inB,
    input  isaDefs::word   inImm,
    input  isaDefs::word   inPc,
    output logic           inReady,
    output logic           outValid,
    output isaDefs::word   outRes,
    output isaDefs::word   outBrAddr,
    output isaDefs::word   outJumpAddr,
    output logic           outErr,
    input  logic           outCredit
);
    import isaDefs::*;
    import clusterDefs::*;

    logic [NUM_LANES-1:0] laneWrite;
    logic [NUM_LANES-1:0] laneCredit;
    logic [NUM_LANES-1:0] resValid;
    logic [NUM_LANES-1:0] resTake;
    logic [NUM_LANES-1:0] laneErr;
    word  [NUM_LANES-1:0] laneRes;
    word  [NUM_LANES-1:0] laneBr;
    word  [NUM_LANES-1:0] laneJump;

    execDispatch i_dispatch (
        .clk        (clk),
        .rstN       (rstN),
        .inValid    (inValid),
        .inReady    (inReady),
        .laneWrite  (laneWrite),
        .laneCredit (laneCredit)
    );

    // Operand bus is shared, laneWrite picks the lane
    for (genvar k = 0; k < NUM_LANES; k++) begin : gLane
        execLane i_lane (
            .clk      (clk),
            .rstN     (rstN),
            .write    (laneWrite[k]),
            .op       (inOp),
            .opA      (inA),
            .opB      (inB),
            .imm      (inImm),
            .pc       (inPc),
            .credit   (laneCredit[k]),
            .resValid (resValid[k]),
            .take     (resTake[k]),
            .res      (laneRes[k]),
            .brAddr   (laneBr[k]),
            .jumpAddr (laneJump[k]),
            .err      (laneErr[k])
        );
    end

    execCollect i_collect (
        .clk         (clk),
        .rstN        (rstN),
        .resValid    (resValid),
        .laneRes     (laneRes),
        .laneBr      (laneBr),
        .laneJump    (laneJump),
        .laneErr     (laneErr),
        .resTake     (resTake),
        .outValid    (outValid),
        .outRes      (outRes),
        .outBrAddr   (outBrAddr),
        .outJumpAddr (outJumpAddr),
        .outErr      (outErr),
        .outCredit   (outCredit)
    );

endmodule

//--- src/execCollect.sv
////////////////////
// Drains lane results in round-robin order so they leave in program
// order; each send spends a downstream credit, outCredit returns one
////////////////////
module execCollect (
    input  logic                                            clk,
    input  logic                                            rstN,
    input  logic         [clusterDefs::NUM_LANES-1:0]       resValid,
    input  isaDefs::word [clusterDefs::NUM_LANES-1:0]       laneRes,
    input  isaDefs::word [clusterDefs::NUM_LANES-1:0]       laneBr,
    input  isaDefs::word [clusterDefs::NUM_LANES-1:0]       laneJump,
    input  logic         [clusterDefs::NUM_LANES-1:0]       laneErr,
    output logic         [clusterDefs::NUM_LANES-1:0]       resTake,
    output logic                                            outValid,
    output isaDefs::word                                    outRes,
    output isaDefs::word                                    outBrAddr,
    output isaDefs::word                                    outJumpAddr,
    output logic                                            outErr,
    input  logic                                            outCredit
);
    import clusterDefs::*;

    laneIdx   ptr;
    creditCnt credits;
    logic     take;

    assign take = resValid[ptr] && (credits != '0);

    always_comb begin
        resTake      = '0;
        resTake[ptr] = take;
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            ptr      <= '0;
            credits  <= creditCnt'(OUT_CREDITS);
            outValid <= 1'b0;
        end else begin
            outValid <= take;
            if (take) begin
                ptr <= (ptr == laneIdx'(NUM_LANES - 1)) ? '0 : ptr + 1'b1;
            end
            credits <= credits - creditCnt'(take) + creditCnt'(outCredit);
        end
    end

    // Output payload
    always_ff @(posedge clk) begin
        if (take) begin
            outRes      <= laneRes[ptr];
            outBrAddr   <= laneBr[ptr];
            outJumpAddr <= laneJump[ptr];
            outErr      <= laneErr[ptr];
        end
    end

    // Consumer never hands back more credits than it holds
    creditBound: assert property (@(posedge clk) disable iff (!rstN)
        credits <= creditCnt'(OUT_CREDITS));

endmodule

//--- src/execDispatch.sv
////////////////////
// Round-robin dispatch of accepted operations to the lanes
// One credit counter per lane, refilled by lane pop pulses
////////////////////
module execDispatch (
    input  logic                              clk,
    input  logic                              rstN,
    input  logic                              inValid,
    output logic                              inReady,
    output logic [clusterDefs::NUM_LANES-1:0] laneWrite,
    input  logic [clusterDefs::NUM_LANES-1:0] laneCredit
);
    import clusterDefs::*;

    creditCnt credits [NUM_LANES];
    laneIdx   ptr;
    logic     accept;

    // Ready follows the credit of the lane whose turn it is
    assign inReady = (credits[ptr] != '0);
    assign accept  = inValid && inReady;

    always_comb begin
        laneWrite      = '0;
        laneWrite[ptr] = accept;
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            ptr <= '0;
            for (int k = 0; k < NUM_LANES; k++) begin
                credits[k] <= creditCnt'(LANE_DEPTH);
            end
        end else begin
            if (accept) begin
                ptr <= (ptr == laneIdx'(NUM_LANES - 1)) ? '0 : ptr + 1'b1;
            end
            for (int k = 0; k < NUM_LANES; k++) begin
                credits[k] <= credits[k] - creditCnt'(laneWrite[k])
                                         + creditCnt'(laneCredit[k]);
            end
        end
    end

    // Lanes never return more credits than they were given
    for (genvar k = 0; k < NUM_LANES; k++) begin : gCreditChk
        creditBound: assert property (@(posedge clk) disable iff (!rstN)
            credits[k] <= creditCnt'(LANE_DEPTH));
    end

endmodule

//--- tests/execModel.svh
////////////////////
// Reference model of one execute operation for the testbench
// Returns {err, jump address, branch address, result}
////////////////////
`ifndef EXEC_MODEL_SVH
`define EXEC_MODEL_SVH

function automatic logic [3*isaDefs::WORD_W:0] predictExec(
    input isaDefs::execOp op,
    input isaDefs::word   a,
    input isaDefs::word   b,
    input isaDefs::word   imm,
    input isaDefs::word   pc
);
    isaDefs::word res;
    isaDefs::word jump;
    logic [16:0]  wide;
    logic [16:0]  brWide;
    logic         ofl;
    int           sh;
    int           i;

    sh  = int'(b[3:0]);
    ofl = 1'b0;
    res = a + b;
    case (op)
        isaDefs::OP_ADD: begin
            res = a + b;
            ofl = (a[15] == b[15]) && (res[15] != a[15]);
        end
        isaDefs::OP_SUB: begin
            // Subtract is B minus A
            res = b - a;
            ofl = (a[15] != b[15]) && (res[15] != b[15]);
        end
        isaDefs::OP_XOR:  res = a ^ b;
        isaDefs::OP_ANDN: res = a & ~b;
        isaDefs::OP_ROL:  res = (a << sh) | (a >> (16 - sh));
        isaDefs::OP_SLL:  res = a << sh;
        isaDefs::OP_ROR:  res = (a >> sh) | (a << (16 - sh));
        isaDefs::OP_SRL:  res = a >> sh;
        isaDefs::OP_SLBI: res = {b[7:0], 8'h00} | imm;
        isaDefs::OP_SEQ:  res = {15'b0, a == b};
        isaDefs::OP_SLT:  res = {15'b0, $signed(a) < $signed(b)};
        isaDefs::OP_SLE:  res = {15'b0, $signed(a) <= $signed(b)};
        isaDefs::OP_SCO: begin
            // Carry out of the unsigned sum
            wide = {1'b0, a} + {1'b0, b};
            res  = {15'b0, wide[16]};
        end
        isaDefs::OP_BTR: begin
            for (i = 0; i < 16; i++) begin
                res[i] = b[15-i];
            end
        end
        default: res = a + b;
    endcase

    jump   = ((op == isaDefs::OP_JR) ? a : pc) + imm;
    brWide = {1'b0, pc} + {1'b0, imm};
    return {ofl | brWide[16], jump, brWide[15:0], res};
endfunction

`endif

//--- tests/execClusterTb.sv
////////////////////
// Testbench of the execute cluster
// Random operations in, credited results out; concurrent assertions
// compare each result with the model and watch credits and stalls
////////////////////
module execClusterTb;
    import isaDefs::*;
    import clusterDefs::*;

    localparam int          CLK_PERIOD     = 100;
    localparam int          DRIVE_DLY      = 10;
    localparam int          RESET_CYCLES   = 5;
    localparam int unsigned RAND_SEED      = 32'hde3b;
    localparam int          NUM_OPCODES    = 15;
    localparam int          NUM_OPS        = 400;
    localparam int          TAIL_OPS       = 40;
    localparam int          ACCEPT_TIMEOUT = 200;
    localparam int          STALL_TIMEOUT  = 100;
    localparam int          STALL_HOLD     = 30;
    localparam int          DRAIN_TIMEOUT  = 1000;
    localparam int          RESULT_W       = 3 * WORD_W + 1;

    `include "execModel.svh"

    logic  clk;
    logic  rstN;
    logic  inValid;
    execOp inOp;
    word   inA;
    word   inB;
    word   inImm;
    word   inPc;
    logic  inReady;
    logic  outValid;
    word   outRes;
    word   outBrAddr;
    word   outJumpAddr;
    logic  outErr;
    logic  outCredit;

    logic [RESULT_W-1:0] expQ [$];
    logic [RESULT_W-1:0] expHead = '0;
    logic [RESULT_W-1:0] outWord;
    int                  expCount      = 0;
    int                  acceptedCount = 0;
    int                  sentCount     = 0;
    int                  returnedCount = 0;
    int                  errCount      = 0;
    logic                withhold;
    logic                stalled;

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    execCluster i_dut (
        .clk         (clk),
        .rstN        (rstN),
        .inValid     (inValid),
        .inOp        (inOp),
        .inA         (inA),
        .inB         (inB),
        .inImm       (inImm),
        .inPc        (inPc),
        .inReady     (inReady),
        .outValid    (outValid),
        .outRes      (outRes),
        .outBrAddr   (outBrAddr),
        .outJumpAddr (outJumpAddr),
        .outErr      (outErr),
        .outCredit   (outCredit)
    );

    assign outWord = {outErr, outJumpAddr, outBrAddr, outRes};

    // Expected results in acceptance order
    always @(posedge clk) begin
        if (rstN) begin
            if (inValid && inReady) begin
                expQ.push_back(predictExec(inOp, inA, inB, inImm, inPc));
                acceptedCount <= acceptedCount + 1;
            end
            if (outValid && expQ.size() != 0) begin
                void'(expQ.pop_front());
            end
            if (outValid) begin
                sentCount <= sentCount + 1;
            end
            if (outCredit) begin
                returnedCount <= returnedCount + 1;
            end
            expHead  <= (expQ.size() != 0) ? expQ[0] : '0;
            expCount <= expQ.size();
        end
    end

    resultMatch: assert property (@(posedge clk) disable iff (!rstN)
        outValid |-> (outWord[RESULT_W-2:0] == expHead[RESULT_W-2:0]))
    else begin
        errCount++;
        $display("Error at %0t: result or address differs from the model", $time);
    end

    errMatch: assert property (@(posedge clk) disable iff (!rstN)
        outValid |-> (outErr == expHead[RESULT_W-1]))
    else begin
        errCount++;
        $display("Error at %0t: err flag differs from the model", $time);
    end

    outputExpected: assert property (@(posedge clk) disable iff (!rstN)
        outValid |-> (expCount != 0))
    else begin
        errCount++;
        $display("Error at %0t: result sent with no operation outstanding", $time);
    end

    creditLimit: assert property (@(posedge clk) disable iff (!rstN)
        sentCount <= returnedCount + OUT_CREDITS)
    else begin
        errCount++;
        $display("Error at %0t: more results sent than credits given", $time);
    end

    noAcceptWhileStalled: assert property (@(posedge clk) disable iff (!rstN)
        stalled |-> !inReady)
    else begin
        errCount++;
        $display("Error at %0t: inReady rose while credits were withheld", $time);
    end

    resetState: assert property (@(posedge clk)
        $rose(rstN) |-> (!outValid && inReady))
    else begin
        errCount++;
        $display("Error at %0t: wrong outValid or inReady after reset", $time);
    end

    // Consumer side, returns credits it holds with random gaps
    initial begin : creditReturn
        int   burstLeft;
        logic hold;
        burstLeft = 0;
        outCredit = 1'b0;
        forever begin
            @(posedge clk);
            hold = withhold;
            #DRIVE_DLY;
            if (burstLeft > 0) begin
                burstLeft--;
            end else if ($urandom_range(99) < 4) begin
                burstLeft = $urandom_range(20, 5);
            end
            outCredit = rstN && !hold && (burstLeft == 0) &&
                        (sentCount > returnedCount) && ($urandom_range(99) < 70);
        end
    end

    task automatic randomizeInputs();
        inOp  = execOp'($urandom_range(NUM_OPCODES - 1));
        inA   = word'($urandom);
        inB   = word'($urandom);
        inImm = word'($urandom);
        inPc  = word'($urandom);
        // Ties now and then for SEQ and SLE
        if ($urandom_range(7) == 0) begin
            inB = inA;
        end
    endtask

    task automatic waitAccept(inout bit timedOut);
        int cycles;
        bit done;
        cycles = 0;
        done   = 1'b0;
        while (!done && !timedOut) begin
            @(posedge clk);
            if (inReady) begin
                done = 1'b1;
            end else begin
                cycles++;
                if (cycles >= ACCEPT_TIMEOUT) begin
                    timedOut = 1'b1;
                    $display("Timed out waiting for inReady at %0t", $time);
                end
            end
        end
        #DRIVE_DLY;
    endtask

    task automatic finishRun(input bit timedOut);
        $display("Summary: %0d accepted, %0d results, %0d errors",
                 acceptedCount, sentCount, errCount);
        if (errCount == 0 && !timedOut) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    endtask

    initial begin : stimulus
        bit timedOut;
        bit stallSeen;
        bit drained;
        int cycles;
        int i;
        void'($urandom(RAND_SEED));
        rstN      = 1'b0;
        inValid   = 1'b0;
        inOp      = '0;
        inA       = '0;
        inB       = '0;
        inImm     = '0;
        inPc      = '0;
        withhold  = 1'b0;
        stalled   = 1'b0;
        timedOut  = 1'b0;
        stallSeen = 1'b0;
        drained   = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DLY;
        rstN = 1'b1;

        // Every opcode once, then a random mix with idle gaps
        for (i = 0; i < NUM_OPS && !timedOut; i++) begin
            if ($urandom_range(4) == 0) begin
                inValid = 1'b0;
                @(posedge clk);
                #DRIVE_DLY;
            end
            randomizeInputs();
            if (i < NUM_OPCODES) begin
                inOp = execOp'(i);
            end
            inValid = 1'b1;
            waitAccept(timedOut);
        end

        // Withhold all credits until the cluster backs up to the input
        if (!timedOut) begin
            withhold = 1'b1;
            randomizeInputs();
            inValid = 1'b1;
            cycles  = 0;
            while (!stallSeen && !timedOut) begin
                @(posedge clk);
                // Stalled only once every downstream credit is spent
                if (!inReady && !outCredit && (sentCount == returnedCount + OUT_CREDITS)) begin
                    stallSeen = 1'b1;
                end else begin
                    cycles++;
                    if (cycles >= STALL_TIMEOUT) begin
                        timedOut = 1'b1;
                        $display("inReady never dropped while credits were withheld");
                    end
                end
                #DRIVE_DLY;
                if (!stallSeen) begin
                    randomizeInputs();
                end
            end
        end
        if (!timedOut) begin
            stalled = 1'b1;
            repeat (STALL_HOLD) @(posedge clk);
            #DRIVE_DLY;
            stalled  = 1'b0;
            withhold = 1'b0;
            waitAccept(timedOut);
        end

        for (i = 0; i < TAIL_OPS && !timedOut; i++) begin
            randomizeInputs();
            inValid = 1'b1;
            waitAccept(timedOut);
        end
        inValid = 1'b0;

        // Everything accepted has to come out
        cycles = 0;
        while (!drained && !timedOut) begin
            @(posedge clk);
            #DRIVE_DLY;
            if (expCount == 0) begin
                drained = 1'b1;
            end else begin
                cycles++;
                if (cycles >= DRAIN_TIMEOUT) begin
                    timedOut = 1'b1;
                    $display("%0d operations never came out of the cluster", expCount);
                end
            end
        end
        repeat (4) @(posedge clk);
        allSent: assert (sentCount == acceptedCount)
        else begin
            errCount++;
            $display("Error at %0t: %0d operations accepted but %0d results sent",
                     $time, acceptedCount, sentCount);
        end
        finishRun(timedOut);
    end

endmodule
